// ==== bench/host_req_assertions.sv ====
// host request checks on stalled outputs, reset state and same-cycle dispatch of pairs.
`timescale 1ns/1ps
`default_nettype none

module host_req_assertions
  import req_types_pkg::*, req_ctrl_pkg::*;
(
  input logic       aclk,
  input logic       rst_n,
  input logic       lrd_valid,
  input logic       lrd_ready,
  input req_t       lrd_data,
  input logic       lwr_valid,
  input logic       lwr_ready,
  input req_t       lwr_data,
  input logic       rrd_valid,
  input logic       rrd_ready,
  input dreq_t      rrd_data,
  input logic       rwr_valid,
  input logic       rwr_ready,
  input dreq_t      rwr_data,
  input logic       reg_rvalid,
  input req_issue_t issue       // router pulses inside the top.
);

  int fail_cnt = 0; // failed checks so far.

  // a stalled port keeps valid high and its request unchanged.
  a_lrd_hold: assert property (@(posedge aclk) disable iff (!rst_n)
    lrd_valid && !lrd_ready |=> lrd_valid && $stable(lrd_data))
    else begin
      $error("lrd changed or dropped a stalled request");
      fail_cnt++;
    end
  a_lwr_hold: assert property (@(posedge aclk) disable iff (!rst_n)
    lwr_valid && !lwr_ready |=> lwr_valid && $stable(lwr_data))
    else begin
      $error("lwr changed or dropped a stalled request");
      fail_cnt++;
    end
  a_rrd_hold: assert property (@(posedge aclk) disable iff (!rst_n)
    rrd_valid && !rrd_ready |=> rrd_valid && $stable(rrd_data))
    else begin
      $error("rrd changed or dropped a stalled request");
      fail_cnt++;
    end
  a_rwr_hold: assert property (@(posedge aclk) disable iff (!rst_n)
    rwr_valid && !rwr_ready |=> rwr_valid && $stable(rwr_data))
    else begin
      $error("rwr changed or dropped a stalled request");
      fail_cnt++;
    end

  // quiet outputs while reset is held.
  a_reset_idle: assert property (@(posedge aclk)
    !rst_n |-> !lrd_valid && !lwr_valid && !rrd_valid && !rwr_valid && !reg_rvalid &&
               issue == '0)
    else begin
      $error("a valid or issue pulse was high during reset");
      fail_cnt++;
    end

  // both halves of a pair show up together when neither output register is blocked.
  a_pair_sync: assert property (@(posedge aclk) disable iff (!rst_n)
    issue.lrd && issue.lwr && (lrd_ready || !lrd_valid) && (lwr_ready || !lwr_valid)
    |=> lrd_valid && lwr_valid)
    else begin
      $error("paired halves did not reach lrd and lwr together");
      fail_cnt++;
    end

endmodule

`default_nettype wire

// ==== bench/tb_host_req.sv ====
// host request testbench: directed routing, stall, remote, enable and counter tests.
`timescale 1ns/1ps
`default_nettype none

module tb_host_req
  import req_types_pkg::*, req_ctrl_pkg::*;
();

  localparam int N_DESC      = 8 + 12 + 24 + 40 + 3; // descriptors over all tests.
  localparam int TEST_CYCLES = N_DESC * 8 + 200;     // stall budget plus register traffic.
  localparam int WAIT_MAX    = 100;                  // cycles a handshake may take.
  localparam int DRAIN_MAX   = 200;                  // cycles for the outputs to empty.

  logic        aclk = 1'b0;
  logic        rst_n;
  logic        sq_valid, sq_ready;
  dreq_t       sq_data;
  logic        lrd_valid, lrd_ready, lwr_valid, lwr_ready;
  req_t        lrd_data, lwr_data;
  logic        rrd_valid, rrd_ready, rwr_valid, rwr_ready;
  dreq_t       rrd_data, rwr_data;
  logic        reg_wr, reg_rd, reg_rvalid;
  reg_addr_e   reg_addr;
  logic [31:0] reg_wdata, reg_rdata;

  integer       seed;
  logic [3:0]   rdy_rand = 4'b0000; // {rwr, rrd, lwr, lrd}, set bit gives a random ready.
  logic         lat_chk  = 1'b0;    // check the 2-cycle latency.
  logic         hold_out = 1'b0;    // no output may go valid.
  int           cyc = 0;
  int           val_errs = 0;
  int           other_errs = 0;
  int           asrt_errs;
  int           n_cnt [5] = '{default: 0}; // expected lrd, lwr, rrd, rwr, drop totals.
  logic [163:0] exp_q [4][$];              // scoreboard per port, locals zero-extended.
  int           acc_q [4][$];              // acceptance cycle of each entry.
  string        port_name [4] = '{"lrd", "lwr", "rrd", "rwr"};

  host_req_top #(.EN_NET(1'b1)) u_host_req_top (.*);

  bind host_req_top host_req_assertions u_host_req_assertions (.*);

  always #2 aclk = ~aclk; // 4 ns period.

  always @(posedge aclk) cyc <= cyc + 1;

  always @(negedge aclk) begin : ready_drive
    logic [31:0] r;
    r = $random(seed);
    {rwr_ready, rrd_ready, lwr_ready, lrd_ready} = ~rdy_rand | r[3:0];
  end

  function automatic dreq_t rand_desc(input int kind); // 0 lrd 1 lwr 2 pair 3 rrd 4 rwr 5 empty.
    logic [191:0] r;
    dreq_t        d;
    r = {$random(seed), $random(seed), $random(seed), $random(seed), $random(seed),
         $random(seed)};
    d = r[163:0];
    d.req_1.actv = (kind == 0 || kind == 2 || kind == 3);
    d.req_2.actv = (kind == 1 || kind == 2 || kind == 4);
    if (kind == 0 || kind == 3) d.req_1.remote = (kind == 3);
    if (kind == 1 || kind == 4) d.req_2.remote = (kind == 4);
    return d; // pair keeps random remote bits, which must be ignored.
  endfunction

  task automatic enqueue(input int p, input logic [163:0] v);
    exp_q[p].push_back(v);
    acc_q[p].push_back(cyc);
    n_cnt[p]++;
  endtask

  // routing rule: pair goes local, single half by its remote bit, empty is dropped.
  task automatic expect_desc(input dreq_t d);
    if (d.req_1.actv && d.req_2.actv) begin
      enqueue(0, {85'd0, d.req_1});
      enqueue(1, {85'd0, d.req_2});
    end else if (d.req_1.actv) begin
      if (d.req_1.remote) enqueue(2, d);
      else enqueue(0, {85'd0, d.req_1});
    end else if (d.req_2.actv) begin
      if (d.req_2.remote) enqueue(3, d);
      else enqueue(1, {85'd0, d.req_2});
    end else begin
      n_cnt[4]++;
    end
  endtask

  task automatic take(input int p, input logic [163:0] got);
    logic [163:0] want;
    int           acc;
    assert (exp_q[p].size() > 0) else begin
      other_errs++;
      $display("%s delivered a request that was never submitted", port_name[p]);
    end
    if (exp_q[p].size() > 0) begin
      want = exp_q[p].pop_front();
      acc  = acc_q[p].pop_front();
      assert (got == want) else begin
        val_errs++;
        $display("ERR %0t: %s data %h, expected %h", $time, port_name[p], got, want);
      end
      if (lat_chk) assert (cyc == acc + 2) else begin
        val_errs++;
        $display("ERR %0t: %s latency %0d cycles, expected 2", $time, port_name[p], cyc - acc);
      end
    end
  endtask

  always @(posedge aclk) begin : monitor
    if (rst_n) begin
      assert (!(hold_out && (lrd_valid || lwr_valid || rrd_valid || rwr_valid))) else begin
        other_errs++;
        $display("an output went valid while submitting was disabled");
      end
      if (lrd_valid && lrd_ready) take(0, {85'd0, lrd_data});
      if (lwr_valid && lwr_ready) take(1, {85'd0, lwr_data});
      if (rrd_valid && rrd_ready) take(2, rrd_data);
      if (rwr_valid && rwr_ready) take(3, rwr_data);
    end
  end

  task automatic send_desc(input dreq_t d, input int limit, output bit taken);
    int n;
    n        = 0;
    taken    = 1'b0;
    sq_valid = 1'b1;
    sq_data  = d;
    while (!taken && n < limit) begin
      @(posedge aclk);
      taken = sq_ready; // sampled before the edge updates.
      n++;
    end
    if (taken) expect_desc(d);
    @(negedge aclk);
    sq_valid = 1'b0;
  endtask

  task automatic submit(input dreq_t d);
    bit ok;
    send_desc(d, WAIT_MAX, ok);
    assert (ok) else begin
      other_errs++;
      $display("sq_ready stayed low for %0d cycles", WAIT_MAX);
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q[0].size() + exp_q[1].size() + exp_q[2].size() + exp_q[3].size() != 0 &&
           n < DRAIN_MAX) begin
      @(negedge aclk);
      n++;
    end
    assert (exp_q[0].size() + exp_q[1].size() + exp_q[2].size() + exp_q[3].size() == 0)
      else begin
        other_errs++;
        $display("requests still missing on the outputs after %0d cycles", DRAIN_MAX);
      end
  endtask

  task automatic reg_write(input reg_addr_e a, input logic [31:0] v);
    reg_wr    = 1'b1;
    reg_addr  = a;
    reg_wdata = v;
    @(negedge aclk);
    reg_wr = 1'b0;
  endtask

  task automatic reg_check(input reg_addr_e a, input logic [31:0] want);
    reg_rd   = 1'b1;
    reg_addr = a;
    @(negedge aclk);
    reg_rd = 1'b0; // response is due now.
    assert (reg_rvalid) else begin
      other_errs++;
      $display("no read response one cycle after the read strobe");
    end
    assert (reg_rdata == want) else begin
      val_errs++;
      $display("ERR %0t: register %0d reads %h, expected %h", $time, a, reg_rdata, want);
    end
  endtask

  task automatic test_single();
    lat_chk = 1'b1;
    for (int i = 0; i < 8; i++) submit(rand_desc(i % 2));
    wait_drain();
    lat_chk = 1'b0;
  endtask

  task automatic test_paired();
    rdy_rand = 4'b0010; // lwr stalls at random.
    for (int i = 0; i < 12; i++) submit(rand_desc(2));
    wait_drain();
    rdy_rand = 4'b0000;
  endtask

  task automatic test_remote();
    for (int i = 0; i < 6; i++) submit(rand_desc(3 + i % 2));
    for (int i = 0; i < 18; i++) submit(rand_desc(i % 6)); // mixed, empties included.
    wait_drain();
  endtask

  task automatic test_backpressure();
    logic [31:0] r;
    rdy_rand = 4'b1111;
    for (int i = 0; i < 40; i++) begin
      r = $random(seed);
      submit(rand_desc(int'(r % 6)));
    end
    wait_drain();
    rdy_rand = 4'b0000;
  endtask

  task automatic test_enable();
    bit    ok;
    dreq_t held;
    reg_write(REG_CTRL, 32'h0);
    hold_out = 1'b1;
    submit(rand_desc(0));
    submit(rand_desc(3)); // second one parks in the skid entry.
    held = rand_desc(1);
    send_desc(held, 8, ok);
    assert (!ok) else begin
      other_errs++;
      $display("a third descriptor was taken while submitting was disabled");
    end
    reg_check(REG_CTRL, 32'h0);
    hold_out = 1'b0;
    reg_write(REG_CTRL, 32'h1);
    if (!ok) submit(held);
    wait_drain();
    for (int i = 0; i < 5; i++) reg_check(reg_addr_e'(i + 1), n_cnt[i]);
    reg_write(REG_CTRL, 32'h3); // clear, keep enabled.
    for (int i = 0; i < 5; i++) reg_check(reg_addr_e'(i + 1), 32'h0);
    reg_check(REG_CTRL, 32'h1);
  endtask

  initial begin : watchdog
    #(TEST_CYCLES * 4);
    $display("watchdog expired after %0d cycles without the tests ending", TEST_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  initial begin : main
    seed      = 32'h525c;
    sq_valid  = 1'b0;
    sq_data   = '0;
    {rwr_ready, rrd_ready, lwr_ready, lrd_ready} = 4'b0000;
    reg_wr    = 1'b0;
    reg_rd    = 1'b0;
    reg_addr  = REG_CTRL;
    reg_wdata = '0;
    rst_n     = 1'b1;
    #1 rst_n  = 1'b0; // edge after time zero so the async reset fires.
    repeat (5) @(posedge aclk);
    @(negedge aclk) rst_n = 1'b1;
    @(negedge aclk);
    test_single();
    test_paired();
    test_remote();
    test_backpressure();
    test_enable();
    repeat (4) @(negedge aclk);
    asrt_errs = u_host_req_top.u_host_req_assertions.fail_cnt;
    $display("errors: value %0d, other %0d, assertion %0d", val_errs, other_errs, asrt_errs);
    if (val_errs + other_errs + asrt_errs == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
hdl/req_types_pkg.sv
hdl/req_ctrl_pkg.sv
hdl/meta_reg.sv
hdl/host_req_mux.sv
hdl/req_ctrl_regs.sv
hdl/host_req_top.sv
bench/host_req_assertions.sv
bench/tb_host_req.sv

// ==== hdl/host_req_mux.sv ====
// host request router: splits submission-queue descriptors onto local and remote request ports.
`timescale 1ns/1ps
`default_nettype none

module host_req_mux
  import req_types_pkg::*, req_ctrl_pkg::*;
#(
  parameter bit EN_NET = 1'b1 // build the remote paths.
) (
  input  logic       aclk,
  input  logic       rst_n,
  input  logic       sq_valid,
  output logic       sq_ready,
  input  dreq_t      sq_data,
  output logic       lrd_valid,
  input  logic       lrd_ready,
  output req_t       lrd_data,
  output logic       lwr_valid,
  input  logic       lwr_ready,
  output req_t       lwr_data,
  output logic       rrd_valid,
  input  logic       rrd_ready,
  output dreq_t      rrd_data,
  output logic       rwr_valid,
  input  logic       rwr_ready,
  output dreq_t      rwr_data,
  input  req_ctrl_t  ctrl,
  output req_issue_t issue
);

  logic  sq_int_valid, sq_int_ready; // sink slice output side.
  dreq_t sq_int_data;
  logic  lrd_int_valid, lrd_int_ready;
  logic  lwr_int_valid, lwr_int_ready;
  logic  rrd_int_valid, rrd_int_ready;
  logic  rwr_int_valid, rwr_int_ready;
  logic  rd_actv, wr_actv, pair;     // active-half decode.
  logic  to_lrd, to_lwr, to_rrd, to_rwr, to_none;
  logic  sq_fire;                    // descriptor leaves the sink slice.

  meta_reg #(.DATA_BITS($bits(dreq_t))) u_reg_sq (
    .aclk(aclk), .rst_n(rst_n),
    .s_valid(sq_valid), .s_ready(sq_ready), .s_data(sq_data),
    .m_valid(sq_int_valid), .m_ready(sq_int_ready), .m_data(sq_int_data)
  );

  assign rd_actv = sq_int_data.req_1.actv;
  assign wr_actv = sq_int_data.req_2.actv;
  assign pair    = rd_actv & wr_actv; // paired is always local.

  // remote bits only count on single halves and only with the network built.
  assign to_rrd  = EN_NET & rd_actv & ~wr_actv & sq_int_data.req_1.remote;
  assign to_rwr  = EN_NET & wr_actv & ~rd_actv & sq_int_data.req_2.remote;
  assign to_lrd  = pair | (rd_actv & ~wr_actv & ~to_rrd);
  assign to_lwr  = pair | (wr_actv & ~rd_actv & ~to_rwr);
  assign to_none = ~rd_actv & ~wr_actv; // empty, consumed and dropped.

  // every chosen slice must be free, a pair waits for both.
  assign sq_int_ready = ctrl.sq_en &
                        (~to_lrd | lrd_int_ready) & (~to_lwr | lwr_int_ready) &
                        (~to_rrd | rrd_int_ready) & (~to_rwr | rwr_int_ready);
  assign sq_fire      = sq_int_valid & sq_int_ready;

  assign lrd_int_valid = sq_fire & to_lrd;
  assign lwr_int_valid = sq_fire & to_lwr;
  assign rrd_int_valid = sq_fire & to_rrd;
  assign rwr_int_valid = sq_fire & to_rwr;

  assign issue.lrd  = lrd_int_valid; // pulses share the sink handshake.
  assign issue.lwr  = lwr_int_valid;
  assign issue.rrd  = rrd_int_valid;
  assign issue.rwr  = rwr_int_valid;
  assign issue.drop = sq_fire & to_none;

  meta_reg #(.DATA_BITS($bits(req_t))) u_reg_lrd (
    .aclk(aclk), .rst_n(rst_n),
    .s_valid(lrd_int_valid), .s_ready(lrd_int_ready), .s_data(sq_int_data.req_1),
    .m_valid(lrd_valid), .m_ready(lrd_ready), .m_data(lrd_data)
  );

  meta_reg #(.DATA_BITS($bits(req_t))) u_reg_lwr (
    .aclk(aclk), .rst_n(rst_n),
    .s_valid(lwr_int_valid), .s_ready(lwr_int_ready), .s_data(sq_int_data.req_2),
    .m_valid(lwr_valid), .m_ready(lwr_ready), .m_data(lwr_data)
  );

  if (EN_NET) begin : g_net
    // remote ports carry the whole descriptor.
    meta_reg #(.DATA_BITS($bits(dreq_t))) u_reg_rrd (
      .aclk(aclk), .rst_n(rst_n),
      .s_valid(rrd_int_valid), .s_ready(rrd_int_ready), .s_data(sq_int_data),
      .m_valid(rrd_valid), .m_ready(rrd_ready), .m_data(rrd_data)
    );

    meta_reg #(.DATA_BITS($bits(dreq_t))) u_reg_rwr (
      .aclk(aclk), .rst_n(rst_n),
      .s_valid(rwr_int_valid), .s_ready(rwr_int_ready), .s_data(sq_int_data),
      .m_valid(rwr_valid), .m_ready(rwr_ready), .m_data(rwr_data)
    );
  end else begin : g_no_net
    assign rrd_int_ready = 1'b0; // never selected.
    assign rwr_int_ready = 1'b0;
    assign rrd_valid     = 1'b0; // remote ports idle.
    assign rwr_valid     = 1'b0;
    assign rrd_data      = '0;
    assign rwr_data      = '0;
  end

endmodule

`default_nettype wire

// ==== hdl/host_req_top.sv ====
// host request top: submission-queue router beside its control and counter register block.
`timescale 1ns/1ps
`default_nettype none

module host_req_top
  import req_types_pkg::*, req_ctrl_pkg::*;
#(
  parameter bit EN_NET = 1'b1 // network option, remote ports built.
) (
  input  logic                aclk,
  input  logic                rst_n,
  input  logic                sq_valid,  // host submission queue.
  output logic                sq_ready,
  input  dreq_t               sq_data,
  output logic                lrd_valid, // local read requests.
  input  logic                lrd_ready,
  output req_t                lrd_data,
  output logic                lwr_valid, // local write requests.
  input  logic                lwr_ready,
  output req_t                lwr_data,
  output logic                rrd_valid, // remote read requests.
  input  logic                rrd_ready,
  output dreq_t               rrd_data,
  output logic                rwr_valid, // remote write requests.
  input  logic                rwr_ready,
  output dreq_t               rwr_data,
  input  logic                reg_wr,    // register strobe port.
  input  logic                reg_rd,
  input  reg_addr_e           reg_addr,
  input  logic [REG_BITS-1:0] reg_wdata,
  output logic [REG_BITS-1:0] reg_rdata,
  output logic                reg_rvalid
);

  req_issue_t issue; // router to counters.
  req_ctrl_t  ctrl;  // registers to router.

  host_req_mux #(.EN_NET(EN_NET)) u_host_req_mux (
    .aclk(aclk), .rst_n(rst_n),
    .sq_valid(sq_valid), .sq_ready(sq_ready), .sq_data(sq_data),
    .lrd_valid(lrd_valid), .lrd_ready(lrd_ready), .lrd_data(lrd_data),
    .lwr_valid(lwr_valid), .lwr_ready(lwr_ready), .lwr_data(lwr_data),
    .rrd_valid(rrd_valid), .rrd_ready(rrd_ready), .rrd_data(rrd_data),
    .rwr_valid(rwr_valid), .rwr_ready(rwr_ready), .rwr_data(rwr_data),
    .ctrl(ctrl),
    .issue(issue)
  );

  req_ctrl_regs #(.EN_NET(EN_NET)) u_req_ctrl_regs (
    .aclk(aclk), .rst_n(rst_n),
    .reg_wr(reg_wr), .reg_rd(reg_rd), .reg_addr(reg_addr),
    .reg_wdata(reg_wdata), .reg_rdata(reg_rdata), .reg_rvalid(reg_rvalid),
    .issue(issue),
    .ctrl(ctrl)
  );

endmodule

`default_nettype wire

// ==== hdl/meta_reg.sv ====
// two-entry valid/ready skid slice with registered data and registered ready.
`timescale 1ns/1ps
`default_nettype none

module meta_reg #(
  parameter int DATA_BITS = 32 // payload width.
) (
  input  logic                 aclk,
  input  logic                 rst_n,
  input  logic                 s_valid,
  output logic                 s_ready,
  input  logic [DATA_BITS-1:0] s_data,
  output logic                 m_valid,
  input  logic                 m_ready,
  output logic [DATA_BITS-1:0] m_data
);

  logic                 skid_valid; // second entry occupied.
  logic [DATA_BITS-1:0] skid_data;  // parked item while output stalls.
  logic                 out_free;   // output register can load this cycle.

  assign out_free = m_ready | ~m_valid;
  assign s_ready  = ~skid_valid; // straight from a flop.

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      m_valid    <= 1'b0;
      skid_valid <= 1'b0;
    end else if (!skid_valid) begin
      if (out_free) begin
        m_valid <= s_valid; // pass through in one cycle.
      end else if (s_valid) begin
        skid_valid <= 1'b1; // park it while the output stalls.
      end
    end else if (m_ready) begin
      m_valid    <= 1'b1; // skid moves forward.
      skid_valid <= 1'b0;
    end
  end

  // payload follows the same decisions.
  always_ff @(posedge aclk) begin
    if (!skid_valid) begin
      if (out_free) begin
        m_data <= s_data;
      end else begin
        skid_data <= s_data;
      end
    end else if (m_ready) begin
      m_data <= skid_data;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/req_ctrl_pkg.sv ====
// register map package: register indices and the event and control structs of the register block.
`default_nettype none

package req_ctrl_pkg;

  localparam int REG_BITS   = 32; // register port width.
  localparam int CNT_BITS   = 32; // dispatch counter width, wraps.
  localparam int NUM_CNT    = 5;  // lrd, lwr, rrd, rwr, drop.
  localparam int CTRL_SQ_EN = 0;  // control bit, submit enable.
  localparam int CTRL_CLR   = 1;  // control bit, counter clear, self-clearing.

  typedef enum logic [2:0] {
    REG_CTRL     = 3'd0, // control register.
    REG_CNT_LRD  = 3'd1, // local reads issued.
    REG_CNT_LWR  = 3'd2, // local writes issued.
    REG_CNT_RRD  = 3'd3, // remote reads issued.
    REG_CNT_RWR  = 3'd4, // remote writes issued.
    REG_CNT_DROP = 3'd5  // empty descriptors discarded.
  } reg_addr_e;

  // single-cycle pulses, one per descriptor leaving the sink slice.
  typedef struct packed {
    logic lrd;
    logic lwr;
    logic rrd;
    logic rwr;
    logic drop;
  } req_issue_t;

  typedef struct packed {
    logic sq_en; // router may take descriptors.
  } req_ctrl_t;

endpackage

`default_nettype wire

// ==== hdl/req_ctrl_regs.sv ====
// router register block: submit enable, counter clear and dispatch counters on a strobe port.
`timescale 1ns/1ps
`default_nettype none

module req_ctrl_regs
  import req_ctrl_pkg::*;
#(
  parameter bit EN_NET = 1'b1 // build the remote counters.
) (
  input  logic                aclk,
  input  logic                rst_n,
  input  logic                reg_wr,
  input  logic                reg_rd,
  input  reg_addr_e           reg_addr,
  input  logic [REG_BITS-1:0] reg_wdata,
  output logic [REG_BITS-1:0] reg_rdata,
  output logic                reg_rvalid,
  input  req_issue_t          issue,
  output req_ctrl_t           ctrl
);

  localparam int CNT_RRD_IDX = int'(REG_CNT_RRD) - int'(REG_CNT_LRD); // counter slots follow
  localparam int CNT_RWR_IDX = int'(REG_CNT_RWR) - int'(REG_CNT_LRD); // the register map.

  logic                               ctrl_wr;  // write to the control register.
  logic                               cnt_clr;  // clear strobe, lasts one cycle.
  logic [NUM_CNT-1:0]                 cnt_inc;  // increment per counter slot.
  logic [NUM_CNT-1:0][CNT_BITS-1:0]   cnt_val;  // current counter values.
  logic [2:0]                         cnt_sel;  // counter slot of reg_addr.
  logic [REG_BITS-1:0]                rd_mux;   // read data before the flop.

  assign ctrl_wr = reg_wr & (reg_addr == REG_CTRL);
  assign cnt_clr = ctrl_wr & reg_wdata[CTRL_CLR]; // bit is never stored.
  assign cnt_inc = {issue.drop, issue.rwr, issue.rrd, issue.lwr, issue.lrd};

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl.sq_en <= 1'b1; // submitting enabled out of reset.
    end else if (ctrl_wr) begin
      ctrl.sq_en <= reg_wdata[CTRL_SQ_EN];
    end
  end

  for (genvar i = 0; i < NUM_CNT; i++) begin : g_cnt
    localparam bit IS_RMT = (i == CNT_RRD_IDX) || (i == CNT_RWR_IDX);
    if (EN_NET || !IS_RMT) begin : g_on
      logic [CNT_BITS-1:0] cnt_q;
      always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
          cnt_q <= '0;
        end else if (cnt_clr) begin
          cnt_q <= '0; // clear wins over a pulse.
        end else if (cnt_inc[i]) begin
          cnt_q <= cnt_q + 1'b1; // wraps.
        end
      end
      assign cnt_val[i] = cnt_q;
    end else begin : g_off
      assign cnt_val[i] = '0; // remote counter not built.
    end
  end

  assign cnt_sel = reg_addr - REG_CNT_LRD;

  always_comb begin
    rd_mux = '0;
    if (reg_addr == REG_CTRL) begin
      rd_mux[CTRL_SQ_EN] = ctrl.sq_en; // clear bit reads 0.
    end else if (reg_addr <= REG_CNT_DROP) begin
      rd_mux = cnt_val[cnt_sel];
    end
  end

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      reg_rvalid <= 1'b0;
    end else begin
      reg_rvalid <= reg_rd; // one cycle after the strobe.
    end
  end

  always_ff @(posedge aclk) begin
    if (reg_rd) begin
      reg_rdata <= rd_mux;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/req_types_pkg.sv ====
// request types package: descriptor layout shared by the submission-queue routing path.
`default_nettype none

package req_types_pkg;

  localparam int VADDR_BITS = 48; // virtual address width.
  localparam int LEN_BITS   = 28; // transfer length in bytes.
  localparam int PID_BITS   = 6;  // host process id.

  // one request half, 79 bits.
  typedef struct packed {
    logic [VADDR_BITS-1:0] vaddr;  // start address.
    logic [LEN_BITS-1:0]   len;    // byte count.
    logic                  remote; // goes to the network side.
    logic                  actv;   // half carries a request.
    logic                  last;   // last request of a transfer.
  } req_t;

  // one submission-queue descriptor, 164 bits.
  typedef struct packed {
    req_t                req_1; // read half.
    req_t                req_2; // write half.
    logic [PID_BITS-1:0] pid;   // owner of both halves.
  } dreq_t;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the host request testbench with Verilator, verdict from the log.
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_host_req \
  -f filelist.f -o sim_host_req
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_host_req +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
  echo "testbench reported failure"
  exit 1
fi
exit 0
